//--- Makefile
TOP = tb_fetch

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

//--- src/fetch_instr_buf.sv
`timescale 1ns/1ns

module fetch_instr_buf
    import fetch_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_arst_n,
    input  logic         i_push,
    input  fetch_entry_t i_entry,
    input  logic         i_req_valid,
    input  logic         i_flush,
    input  logic         i_drop,
    input  logic         i_stall,
    output logic         o_has_space,
    output fetch_entry_t o_entry,
    output logic         o_ready
);

    fetch_entry_t         mem [buf_depth];
    logic [buf_ptr_w-1:0] wr_ptr;
    logic [buf_ptr_w-1:0] rd_ptr;
    logic [buf_ptr_w:0]   count;
    logic [buf_ptr_w:0]   occupied;
    logic                 drop_pending;
    logic                 in_flight;
    logic                 pop;

    // a prediction squashes the word acked in the same cycle
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            drop_pending <= 1'b0;
        end
        else
        begin
            drop_pending <= i_drop & ~i_flush;
        end
    end

    // word on the bus this cycle, not yet written but bound for a slot
    assign in_flight = i_req_valid & ~drop_pending;
    assign occupied  = count + {{buf_ptr_w{1'b0}}, in_flight};

    // one more slot is needed for the word that may be acked now
    assign o_has_space = occupied < (buf_ptr_w + 1)'(buf_depth);

    assign o_ready = (count != '0);
    assign o_entry = mem[rd_ptr];
    assign pop     = o_ready & ~i_stall;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (i_flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (i_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            unique case ({i_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_push)
        begin
            mem[wr_ptr] <= i_entry;
        end
    end

endmodule

//--- src/fetch_pc_gen.sv
`timescale 1ns/1ns

module fetch_pc_gen
    import fetch_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_arst_n,
    input  redirect_t    i_redirect,
    input  logic         i_pc_select,
    input  logic [31:0]  i_pc_target,
    input  logic         i_trap,
    input  logic [31:0]  i_trap_pc,
    input  logic         i_ack,
    input  logic         i_has_space,
    output logic         o_cyc,
    output logic [31:0]  o_addr,
    output fetch_entry_t o_req,
    output logic         o_req_valid
);

    logic        run;
    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] req_pc;
    logic        ext_redirect;
    logic        req_acc;

    assign ext_redirect = i_trap | i_pc_select;

    // no request while execute changes the flow, the old pc is stale
    assign o_cyc   = run & i_has_space & ~ext_redirect;
    assign req_acc = o_cyc & i_ack;
    assign o_addr  = pc;

    // trap, then execute redirect, then prediction, then sequential
    always_comb
    begin
        if (i_trap)
        begin
            pc_next = i_trap_pc;
        end
        else if (i_pc_select)
        begin
            pc_next = i_pc_target;
        end
        else if (i_redirect.valid)
        begin
            pc_next = i_redirect.target;
        end
        else if (req_acc)
        begin
            pc_next = pc + 32'd4;
        end
        else
        begin
            pc_next = pc;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            run         <= 1'b0;
            pc          <= reset_addr;
            o_req_valid <= 1'b0;
        end
        else
        begin
            run         <= 1'b1;
            pc          <= pc_next;
            o_req_valid <= req_acc;
        end
    end

    // pc of the word that the bus returns in the next cycle
    always_ff @(posedge i_clk)
    begin
        if (req_acc)
        begin
            req_pc <= pc;
        end
    end

    assign o_req = '{pc: req_pc, instr: 32'd0, pred: 1'b0};

endmodule

//--- src/fetch_pkg.sv
package fetch_pkg;

    // first word fetched after reset
    localparam logic [31:0] reset_addr = 32'h0000_0000;

    // fetch queue geometry, depth is a power of two
    localparam int buf_depth = 4;
    localparam int buf_ptr_w = 2;

    // one fetched word on its way to decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        // word caused a predicted redirect
        logic        pred;
    } fetch_entry_t;

    // change of fetch flow requested by the predictor
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

//--- src/fetch_predictor.sv
`timescale 1ns/1ns

module fetch_predictor
    import rv_isa_pkg::*;
    import fetch_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_arst_n,
    input  fetch_entry_t i_req,
    input  logic         i_req_valid,
    input  logic [31:0]  i_instr,
    input  logic         i_flush,
    input  logic         i_reg_write,
    input  logic [4:0]   i_rd,
    input  logic [31:0]  i_reg_wdata,
    input  logic         i_ra_invalidate,
    output logic         o_push,
    output fetch_entry_t o_entry,
    output redirect_t    o_redirect
);

    rv_instr_t   word;
    logic [31:0] ra;
    logic        ra_valid;
    logic        squash;
    logic        live;
    logic        is_branch;
    logic        is_jal;
    logic        is_ret;
    logic        predict;
    logic [31:0] branch_off;
    logic [31:0] ret_addr;
    logic [31:0] target;

    // tracked copy of x1 for return prediction
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            ra_valid <= 1'b0;
        end
        else if (i_ra_invalidate)
        begin
            ra_valid <= 1'b0;
        end
        else if (i_reg_write && (i_rd == reg_ra))
        begin
            ra_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reg_write && (i_rd == reg_ra))
        begin
            ra <= i_reg_wdata;
        end
    end

    assign word       = i_instr;
    assign branch_off = imm_b(word);

    // backward branches are assumed taken and forward ones are not
    assign is_branch = (word.b_type.opcode == opc_branch) && branch_off[31];
    assign is_jal    = (word.j_type.opcode == opc_jal);
    assign is_ret    = (word.i_type.opcode == opc_jalr) && (word.i_type.funct3 == 3'b000) &&
                       (word.i_type.rs1 == reg_ra) && ra_valid && !i_ra_invalidate;

    assign ret_addr = ra + imm_i(word);

    always_comb
    begin
        if (is_branch)
        begin
            target = i_req.pc + branch_off;
        end
        else if (is_jal)
        begin
            target = i_req.pc + imm_j(word);
        end
        else
        begin
            // jalr clears bit 0 of the sum
            target = {ret_addr[31:1], 1'b0};
        end
    end

    // the word after a predicted one was fetched on the old path
    assign live    = i_req_valid & ~i_flush & ~squash;
    assign predict = live & (is_branch | is_jal | is_ret);

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            squash <= 1'b0;
        end
        else
        begin
            squash <= predict;
        end
    end

    assign o_push     = live;
    assign o_entry    = '{pc: i_req.pc, instr: i_instr, pred: predict};
    assign o_redirect = '{valid: predict, target: target};

endmodule

//--- src/rv_fetch_unit.sv
`timescale 1ns/1ns

module rv_fetch_unit
    import fetch_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_arst_n,
    input  logic         i_stall,
    input  logic         i_pc_select,
    input  logic [31:0]  i_pc_target,
    input  logic         i_trap,
    input  logic [31:0]  i_trap_pc,
    input  logic         i_ack,
    input  logic [31:0]  i_instr,
    input  logic         i_ra_invalidate,
    input  logic         i_reg_write,
    input  logic [4:0]   i_rd,
    input  logic [31:0]  i_reg_wdata,
    output logic         o_cyc,
    output logic [31:0]  o_addr,
    output fetch_entry_t o_entry,
    output logic         o_ready
);

    logic         flush;
    fetch_entry_t req;
    logic         req_valid;
    fetch_entry_t push_entry;
    logic         push;
    redirect_t    redirect;
    logic         has_space;

    // execute changes the flow, everything fetched so far is stale
    assign flush = i_pc_select | i_trap;

    fetch_pc_gen pc_gen_i (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_redirect  (redirect),
        .i_pc_select (i_pc_select),
        .i_pc_target (i_pc_target),
        .i_trap      (i_trap),
        .i_trap_pc   (i_trap_pc),
        .i_ack       (i_ack),
        .i_has_space (has_space),
        .o_cyc       (o_cyc),
        .o_addr      (o_addr),
        .o_req       (req),
        .o_req_valid (req_valid)
    );

    fetch_predictor predictor_i (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .i_req           (req),
        .i_req_valid     (req_valid),
        .i_instr         (i_instr),
        .i_flush         (flush),
        .i_reg_write     (i_reg_write),
        .i_rd            (i_rd),
        .i_reg_wdata     (i_reg_wdata),
        .i_ra_invalidate (i_ra_invalidate),
        .o_push          (push),
        .o_entry         (push_entry),
        .o_redirect      (redirect)
    );

    fetch_instr_buf instr_buf_i (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_push      (push),
        .i_entry     (push_entry),
        .i_req_valid (req_valid),
        .i_flush     (flush),
        .i_drop      (redirect.valid),
        .i_stall     (i_stall),
        .o_has_space (has_space),
        .o_entry     (o_entry),
        .o_ready     (o_ready)
    );

endmodule

//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes of the control transfer instructions
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    // x1 holds the return address by calling convention
    localparam logic [4:0] reg_ra = 5'd1;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef union packed {
        b_type_t b_type;
        j_type_t j_type;
        i_type_t i_type;
    } rv_instr_t;

    function automatic logic [31:0] imm_b(rv_instr_t w);
        return {{20{w.b_type.imm12}}, w.b_type.imm11, w.b_type.imm10_5, w.b_type.imm4_1, 1'b0};
    endfunction

    function automatic logic [31:0] imm_j(rv_instr_t w);
        return {{12{w.j_type.imm20}}, w.j_type.imm19_12, w.j_type.imm11, w.j_type.imm10_1, 1'b0};
    endfunction

    function automatic logic [31:0] imm_i(rv_instr_t w);
        return {{20{w.i_type.imm[11]}}, w.i_type.imm};
    endfunction

endpackage

//--- tb.f
src/rv_isa_pkg.sv
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/fetch_predictor.sv
src/fetch_instr_buf.sv
src/rv_fetch_unit.sv
test/tb_fetch_assert.sv
test/tb_fetch_checker.sv
test/tb_fetch.sv

//--- test/tb_fetch.sv
`timescale 1ns/1ns

module tb_fetch
    import rv_isa_pkg::*;
    import fetch_pkg::*;
();

    localparam int num_tests = 8;

    typedef struct {
        logic [31:0] start;
        bit          reg_write;
        logic [31:0] ra_value;
        bit          ra_inv;
        int          redir;
        logic [31:0] pc_target;
        logic [31:0] trap_pc;
        int          stall;
        int          count;
    } test_row_t;

    // start, write x1, x1 value, invalidate x1, redirect (1 pc_select, 2 trap, 3 both),
    // pc target, trap pc, stall cycles, expected entries
    test_row_t tests [num_tests] = '{
        '{32'h000, 1'b0, 32'h000, 1'b0, 0, 32'h000, 32'h000, 0, 12},
        '{32'h100, 1'b0, 32'h000, 1'b0, 0, 32'h000, 32'h000, 0, 14},
        '{32'h200, 1'b1, 32'h280, 1'b0, 0, 32'h000, 32'h000, 0, 8},
        '{32'h200, 1'b0, 32'h000, 1'b1, 0, 32'h000, 32'h000, 0, 6},
        '{32'h000, 1'b0, 32'h000, 1'b0, 1, 32'h300, 32'h000, 6, 6},
        '{32'h000, 1'b0, 32'h000, 1'b0, 3, 32'h340, 32'h380, 6, 6},
        '{32'h040, 1'b0, 32'h000, 1'b0, 2, 32'h000, 32'h3c0, 6, 6},
        '{32'h020, 1'b0, 32'h000, 1'b0, 0, 32'h000, 32'h000, 30, 10}
    };

    logic         i_clk, i_arst_n, i_stall, i_pc_select, i_trap, i_ack;
    logic         i_ra_invalidate, i_reg_write, o_cyc, o_ready;
    logic [31:0]  i_pc_target, i_trap_pc, i_instr, i_reg_wdata, o_addr;
    logic [4:0]   i_rd;
    fetch_entry_t o_entry;

    logic [31:0]  prog [256];
    logic         acc_valid = 1'b0;
    logic [31:0]  acc_addr = 32'd0;
    logic [31:0]  lcg_state = 32'h5d67_32a7;
    logic [31:0]  ra_model = 32'd0;
    logic         ra_valid_model = 1'b0;
    int           cycles = 0;
    int           limit = 200;

    rv_fetch_unit rv_fetch_unit_i (.*);

    tb_fetch_checker check_i (
        .i_clk   (i_clk),
        .i_ready (o_ready),
        .i_stall (i_stall),
        .i_flush (i_pc_select | i_trap),
        .i_entry (o_entry)
    );

    bind rv_fetch_unit tb_fetch_assert assert_i (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_flush  (flush),
        .i_stall  (i_stall),
        .i_ready  (o_ready),
        .i_addr   (o_addr),
        .i_entry  (o_entry)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // rs1 x5, rs2 x6
    function automatic logic [31:0] encode_branch(logic [12:0] imm, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd6, 5'd5, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] encode_jal(logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, opc_jal};
    endfunction

    function automatic logic [31:0] encode_jalr(logic [11:0] imm, logic [4:0] rs1);
        return {imm, rs1, 3'b000, 5'd0, opc_jalr};
    endfunction

    // addi with rd and immediate taken from the word index
    function automatic logic [31:0] fill_word(logic [7:0] idx);
        return {4'h0, idx, 5'd0, 3'b000, idx[4:0], 7'b0010011};
    endfunction

    task automatic put_word(logic [31:0] addr, logic [31:0] w);
        prog[addr[9:2]] = w;
    endtask

    // walk the program the way decode should see it
    task automatic load_expected(logic [31:0] start, int count);
        rv_instr_t    w;
        fetch_entry_t e;
        logic [31:0]  pc;
        logic [31:0]  ib;
        logic [31:0]  sum;
        logic [31:0]  next_pc;
        pc = start;
        for (int n = 0; n < count; n++)
        begin
            w = prog[pc[9:2]];
            ib = imm_b(w);
            sum = ra_model + imm_i(w);
            e.pred = 1'b1;
            if (w.b_type.opcode == opc_branch && ib[31])
                next_pc = pc + ib;
            else if (w.j_type.opcode == opc_jal)
                next_pc = pc + imm_j(w);
            else if (w.i_type.opcode == opc_jalr && w.i_type.funct3 == 3'b000 &&
                     w.i_type.rs1 == reg_ra && ra_valid_model)
                next_pc = {sum[31:1], 1'b0};
            else
            begin
                e.pred = 1'b0;
                next_pc = pc + 32'd4;
            end
            e.pc = pc;
            e.instr = w;
            check_i.add_expected(e);
            pc = next_pc;
        end
    endtask

    task automatic run_test(int t);
        test_row_t   row;
        logic [31:0] first_pc;
        int          cyc;
        row = tests[t];
        @(posedge i_clk);
        #5;
        if (row.reg_write)
        begin
            ra_model = row.ra_value;
            ra_valid_model = 1'b1;
        end
        if (row.ra_inv)
            ra_valid_model = 1'b0;
        if (row.redir >= 2)
            first_pc = row.trap_pc;
        else if (row.redir == 1)
            first_pc = row.pc_target;
        else
            first_pc = row.start;
        check_i.start_test();
        load_expected(first_pc, row.count);
        // the trap to the start address clears what the last test left behind
        i_trap = 1'b1;
        i_trap_pc = row.start;
        i_reg_write = row.reg_write;
        i_rd = reg_ra;
        i_reg_wdata = row.ra_value;
        i_ra_invalidate = row.ra_inv;
        i_stall = (row.stall != 0);
        cyc = 0;
        while (check_i.got < row.count)
        begin
            @(posedge i_clk);
            #5;
            cyc++;
            i_trap = 1'b0;
            i_pc_select = 1'b0;
            i_reg_write = 1'b0;
            i_ra_invalidate = 1'b0;
            i_stall = (cyc < row.stall);
            if (row.redir != 0 && cyc == row.stall - 1)
            begin
                i_pc_select = (row.redir & 1) != 0;
                i_pc_target = row.pc_target;
                i_trap = (row.redir & 2) != 0;
                i_trap_pc = row.trap_pc;
            end
        end
        i_stall = 1'b1;
        check_i.finish_test(t);
    endtask

    initial
    begin
        i_clk = 1'b0;
        forever
        begin
            #20 i_clk = ~i_clk;
        end
    end

    // sampled at the falling edge, where the request is settled
    always @(negedge i_clk)
    begin
        acc_valid <= o_cyc & i_ack;
        acc_addr  <= o_addr;
    end

    always @(posedge i_clk)
    begin
        #5;
        i_instr = acc_valid ? prog[acc_addr[9:2]] : 32'd0;
        i_ack   = (lcg_next() >= 32'h4000_0000);
    end

    always @(posedge i_clk)
    begin
        cycles = cycles + 1;
        if (cycles > limit)
        begin
            $display("timeout: decode did not receive all expected entries in %0d cycles", limit);
            $display("Finished with errors");
            $finish;
        end
    end

    initial
    begin
        i_arst_n = 1'b0;
        i_stall = 1'b1;
        i_pc_select = 1'b0;
        i_pc_target = 32'd0;
        i_trap = 1'b0;
        i_trap_pc = 32'd0;
        i_ack = 1'b0;
        i_instr = 32'd0;
        i_ra_invalidate = 1'b0;
        i_reg_write = 1'b0;
        i_rd = 5'd0;
        i_reg_wdata = 32'd0;
        for (int i = 0; i < 256; i++)
            prog[i] = fill_word(8'(i));
        put_word(32'h104, encode_branch(13'd12, 3'b001));
        put_word(32'h10c, encode_jal(21'h40));
        put_word(32'h150, encode_branch(-13'sd16, 3'b100));
        put_word(32'h208, encode_jalr(12'd8, reg_ra));
        for (int t = 0; t < num_tests; t++)
            limit += (tests[t].count + tests[t].stall) * 8;
        repeat (10) @(posedge i_clk);
        #5 i_arst_n = 1'b1;
        for (int t = 0; t < num_tests; t++)
            run_test(t);
        @(posedge i_clk);
        $display("%0d tests, %0d failed, %0d errors, %0d assertion failures", num_tests,
                 check_i.fail_count, check_i.error_count, rv_fetch_unit_i.assert_i.fail_count);
        if (check_i.error_count == 0 && rv_fetch_unit_i.assert_i.fail_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- test/tb_fetch_assert.sv
`timescale 1ns/1ns

module tb_fetch_assert
    import fetch_pkg::*;
(
    input logic         i_clk,
    input logic         i_arst_n,
    input logic         i_flush,
    input logic         i_stall,
    input logic         i_ready,
    input logic [31:0]  i_addr,
    input fetch_entry_t i_entry
);

    int fail_count = 0;

    // no compressed instructions, so every fetch is a whole word
    addr_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_addr[1:0] == 2'b00)
    else
    begin
        $error("o_addr %08h is not word-aligned", i_addr);
        fail_count++;
    end

    empty_after_flush: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_flush |=> !i_ready)
    else
    begin
        $error("o_ready high in the cycle after a flush");
        fail_count++;
    end

    held_while_stalled: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_ready && i_stall && !i_flush) |=> $stable(i_entry))
    else
    begin
        $error("o_entry changed while decode stalled");
        fail_count++;
    end

endmodule

//--- test/tb_fetch_checker.sv
`timescale 1ns/1ns

module tb_fetch_checker
    import fetch_pkg::*;
(
    input logic         i_clk,
    input logic         i_ready,
    input logic         i_stall,
    input logic         i_flush,
    input fetch_entry_t i_entry
);

    fetch_entry_t expected [$];
    int           got = 0;
    int           test_errors = 0;
    int           error_count = 0;
    int           fail_count = 0;

    task automatic start_test();
        expected.delete();
        got = 0;
        test_errors = 0;
    endtask

    task automatic add_expected(fetch_entry_t e);
        expected.push_back(e);
    endtask

    task automatic finish_test(int t);
        if (test_errors == 0)
            $display("test %0d: passed, %0d entries", t, got);
        else
        begin
            $display("test %0d: failed with %0d errors", t, test_errors);
            fail_count++;
        end
    endtask

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("error: %s expected %08h got %08h", name, exp, act);
        test_errors++;
        error_count++;
    endtask

    // decode takes the head entry when it is ready, not stalled and not flushed
    always @(negedge i_clk)
    begin
        if (i_ready && !i_stall && !i_flush)
        begin
            if (got >= expected.size())
            begin
                $display("entry at pc %08h reached decode after the stream ended", i_entry.pc);
                test_errors++;
                error_count++;
            end
            else
            begin
                if (i_entry.pc !== expected[got].pc)
                    report_mismatch("o_entry.pc", expected[got].pc, i_entry.pc);
                if (i_entry.instr !== expected[got].instr)
                    report_mismatch("o_entry.instr", expected[got].instr, i_entry.instr);
                if (i_entry.pred !== expected[got].pred)
                    report_mismatch("o_entry.pred", 32'(expected[got].pred), 32'(i_entry.pred));
            end
            got++;
        end
    end

endmodule
